//--- logic/isa_pkg.sv
// Instruction encoding: opcode enum, field positions and widths, special register numbers
package isa_pkg;

	// ==================================================
	// Word sizes
	// ==================================================

	// Width of one instruction word, also the width of each postfix word
	localparam int INSN_W = 48;

	// Width of the immediates that the decoder produces
	localparam int IMM_W = 64;

	// ==================================================
	// Opcodes
	// ==================================================

	// Codes that are not listed here decode with no immediates
	typedef enum logic [6:0] {
		OP_R3    = 7'd2,
		OP_ADDI  = 7'd4,
		OP_ANDI  = 7'd8,
		OP_ORI   = 7'd9,
		OP_LOADI = 7'd12,
		OP_BCC   = 7'd40,
		OP_LOAD  = 7'd64,
		OP_STORE = 7'd80,
		OP_FENCE = 7'd119
	} opcode_e;

	// ==================================================
	// Field positions
	// ==================================================

	// Opcode sits in the lowest bits of the word
	localparam int OPC_POS = 0;
	localparam int OPC_W   = 7;

	// All register fields are six bits wide
	localparam int REG_W   = 6;
	localparam int RD_POS  = 7;
	localparam int RS1_POS = 13;
	localparam int RS2_POS = 19;
	localparam int RS3_POS = 25;

	// Memory displacement of loads and stores, overlaps the upper register fields
	localparam int IMM20_POS = 28;
	localparam int IMM20_W   = 20;

	// Quick immediate of the ALU immediate forms
	localparam int IMM28_POS = 20;
	localparam int IMM28_W   = 28;

	// Fence carries a 16-bit operand field in the middle of the word
	localparam int FENCE_POS = 8;
	localparam int FENCE_W   = 16;

	// ==================================================
	// Special registers
	// ==================================================

	// Reads as zero
	localparam logic [REG_W-1:0] REG_ZERO = 6'd63;

	// Reads as the instruction pointer when ip-relative addressing is on
	localparam logic [REG_W-1:0] REG_IP = 6'd62;

endpackage

//--- logic/postfix_pkg.sv
// Postfix word format: marker, slot enum, half bit, payload width, configuration addresses
package postfix_pkg;

	// ==================================================
	// Postfix word layout
	// ==================================================

	// The low byte of a postfix word holds this marker
	localparam int MARK_POS = 0;
	localparam int MARK_W   = 8;
	localparam logic [MARK_W-1:0] PFX_MARK = 8'd127;

	// Operand slot that the postfix word feeds
	localparam int SLOT_POS = 8;
	localparam int SLOT_W   = 2;

	typedef enum logic [SLOT_W-1:0] {
		SLOT_A = 2'd0,
		SLOT_B = 2'd1,
		SLOT_C = 2'd2,
		SLOT_D = 2'd3
	} slot_e;

	// Zero selects the low half of the constant, one the high half
	localparam int HALF_BIT = 10;

	// Payload bits of a postfix word
	localparam int PAY_POS = 12;
	localparam int PAY_W   = 36;

	// A full constant and the part that a high-half word supplies
	localparam int CNST_W = 64;
	localparam int HI_W   = CNST_W - PAY_W;

	// ==================================================
	// Configuration register map
	// ==================================================

	typedef enum logic [0:0] {
		CFG_MAX_PFX = 1'b0,
		CFG_IP_REL  = 1'b1
	} cfg_addr_e;

endpackage

//--- logic/decode_cfg.sv
// Decoder configuration registers: postfix limit, ip-relative enable, write and readback port
module decode_cfg #(
	parameter int NUM_PFX = 6
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cfg_we,
	input  postfix_pkg::cfg_addr_e cfg_addr,
	input  logic [7:0]             cfg_wdata,
	output logic [7:0]             cfg_rdata,
	output logic [2:0]             max_pfx,
	output logic                   ip_rel_en
);

	// ==================================================
	// Register writes
	// ==================================================

	// The limit comes out of reset at the full group size and ip-relative on
	always_ff @(posedge clk) begin
		if (reset) begin
			max_pfx   <= 3'(NUM_PFX);
			ip_rel_en <= 1'b1;
		end else if (cfg_we) begin
			case (cfg_addr)
				postfix_pkg::CFG_MAX_PFX: begin
					// A group never holds more than NUM_PFX postfix words,
					// so a larger limit is stored as NUM_PFX
					if (cfg_wdata > 8'(NUM_PFX))
						max_pfx <= 3'(NUM_PFX);
					else
						max_pfx <= cfg_wdata[2:0];
				end
				postfix_pkg::CFG_IP_REL: begin
					// Only bit 0 is kept
					ip_rel_en <= cfg_wdata[0];
				end
			endcase
		end
	end

	// ==================================================
	// Readback
	// ==================================================

	// The addressed register shows right away and is zero-extended to the bus width
	always_comb begin
		case (cfg_addr)
			postfix_pkg::CFG_MAX_PFX: cfg_rdata = {5'd0, max_pfx};
			postfix_pkg::CFG_IP_REL:  cfg_rdata = {7'd0, ip_rel_en};
			default:                  cfg_rdata = 8'd0;
		endcase
	end

endmodule

//--- logic/postfix_scan.sv
// First decode stage: postfix run detection, per-slot constant assembly, stage registers
module postfix_scan #(
	parameter int NUM_PFX = 6
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  in_valid,
	input  logic [isa_pkg::INSN_W*(NUM_PFX+1)-1:0] in_group,
	input  logic [63:0]                           in_ip,
	input  logic [2:0]                            max_pfx,
	input  logic                                  ip_rel_en,
	output logic                                  st_valid,
	output logic [47:0]                           st_insn,
	output logic [63:0]                           st_ip,
	output logic                                  st_ip_rel_en,
	output logic [63:0]                           cnsta,
	output logic [63:0]                           cnstb,
	output logic [63:0]                           cnstc,
	output logic [63:0]                           cnstd,
	output logic                                  has_cnsta,
	output logic                                  has_cnstb,
	output logic                                  has_cnstc,
	output logic                                  has_cnstd,
	output logic [2:0]                            st_pfx_used
);

	// Constants and flags as they build up across the run, indexed by slot
	logic [postfix_pkg::CNST_W-1:0] cnst_nx [4];
	logic                           has_nx [4];

	// Current postfix word and its fields
	logic [isa_pkg::INSN_W-1:0]    pfx_word;
	postfix_pkg::slot_e            pfx_slot;
	logic [postfix_pkg::PAY_W-1:0] pfx_pay;

	// Run still going, and the number of words it has taken so far
	logic       run_on;
	logic [2:0] run_len;

	// ==================================================
	// Postfix run scan
	// ==================================================

	// Words are applied in group order, so a later word for a slot wins
	always_comb begin
		run_on  = 1'b1;
		run_len = 3'd0;
		pfx_word = '0;
		pfx_slot = postfix_pkg::SLOT_A;
		pfx_pay  = '0;
		for (int s = 0; s < 4; s++) begin
			cnst_nx[s] = '0;
			has_nx[s]  = 1'b0;
		end
		for (int n = 0; n < NUM_PFX; n++) begin
			// Word 0 of the group is the instruction itself
			pfx_word = in_group[(n+1)*isa_pkg::INSN_W +: isa_pkg::INSN_W];
			pfx_slot = postfix_pkg::slot_e'(pfx_word[postfix_pkg::SLOT_POS +: postfix_pkg::SLOT_W]);
			pfx_pay  = pfx_word[postfix_pkg::PAY_POS +: postfix_pkg::PAY_W];
			// The run ends at the first unmarked word or at the limit
			if (run_on && (n < int'(max_pfx)) &&
				pfx_word[postfix_pkg::MARK_POS +: postfix_pkg::MARK_W] == postfix_pkg::PFX_MARK) begin
				if (!pfx_word[postfix_pkg::HALF_BIT]) begin
					// Low half, sign-extended from the payload
					cnst_nx[pfx_slot] = {{postfix_pkg::HI_W{pfx_pay[postfix_pkg::PAY_W-1]}}, pfx_pay};
				end else begin
					// High half replaces the upper bits and keeps the low part
					cnst_nx[pfx_slot] = {pfx_pay[postfix_pkg::HI_W-1:0],
						cnst_nx[pfx_slot][postfix_pkg::PAY_W-1:0]};
				end
				has_nx[pfx_slot] = 1'b1;
				run_len = run_len + 3'd1;
			end else begin
				run_on = 1'b0;
			end
		end
	end

	// ==================================================
	// Stage registers
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			st_valid  <= 1'b0;
			has_cnsta <= 1'b0;
			has_cnstb <= 1'b0;
			has_cnstc <= 1'b0;
			has_cnstd <= 1'b0;
		end else begin
			st_valid  <= in_valid;
			has_cnsta <= has_nx[postfix_pkg::SLOT_A];
			has_cnstb <= has_nx[postfix_pkg::SLOT_B];
			has_cnstc <= has_nx[postfix_pkg::SLOT_C];
			has_cnstd <= has_nx[postfix_pkg::SLOT_D];
		end
	end

	// The ip-relative enable travels with its group from here on
	always_ff @(posedge clk) begin
		st_insn      <= in_group[isa_pkg::INSN_W-1:0];
		st_ip        <= in_ip;
		st_ip_rel_en <= ip_rel_en;
		st_pfx_used  <= run_len;
		cnsta        <= cnst_nx[postfix_pkg::SLOT_A];
		cnstb        <= cnst_nx[postfix_pkg::SLOT_B];
		cnstc        <= cnst_nx[postfix_pkg::SLOT_C];
		cnstd        <= cnst_nx[postfix_pkg::SLOT_D];
	end

endmodule

//--- logic/imm_select.sv
// Second decode stage: opcode-driven immediate selection, present flags, output registers
module imm_select (
	input  logic        clk,
	input  logic        reset,
	input  logic        st_valid,
	input  logic [47:0] st_insn,
	input  logic [63:0] st_ip,
	input  logic        st_ip_rel_en,
	input  logic [63:0] cnsta,
	input  logic [63:0] cnstb,
	input  logic [63:0] cnstc,
	input  logic [63:0] cnstd,
	input  logic        has_cnsta,
	input  logic        has_cnstb,
	input  logic        has_cnstc,
	input  logic        has_cnstd,
	input  logic [2:0]  st_pfx_used,
	output logic        out_valid,
	output logic [63:0] imma,
	output logic [63:0] immb,
	output logic [63:0] immc,
	output logic [63:0] immd,
	output logic        has_imma,
	output logic        has_immb,
	output logic        has_immc,
	output logic        has_immd,
	output logic [2:0]  pfx_used
);

	// Decoded instruction fields
	isa_pkg::opcode_e                  opc;
	logic [isa_pkg::REG_W-1:0]         rd;
	logic [isa_pkg::REG_W-1:0]         rs1;
	logic [isa_pkg::REG_W-1:0]         rs2;
	logic [isa_pkg::REG_W-1:0]         rs3;
	logic [isa_pkg::IMM20_W-1:0]       imm20;
	logic [isa_pkg::IMM28_W-1:0]       imm28;

	// Immediates and flags before the output register
	logic [isa_pkg::IMM_W-1:0] imma_nx;
	logic [isa_pkg::IMM_W-1:0] immb_nx;
	logic [isa_pkg::IMM_W-1:0] immc_nx;
	logic [isa_pkg::IMM_W-1:0] immd_nx;
	logic has_a_nx;
	logic has_b_nx;
	logic has_c_nx;
	logic has_d_nx;

	// Register field with the constant stacked above it, cut to 64 bits
	function automatic logic [63:0] ext_reg(input logic [63:0] cnst, input logic [5:0] fld);
		return {cnst[63-isa_pkg::REG_W:0], fld};
	endfunction

	// Quick immediate, either extended by a constant or sign-extended
	function automatic logic [63:0] quick_imm(input logic has, input logic [63:0] cnst,
		input logic [27:0] imm);
		if (has)
			return {cnst[63-isa_pkg::IMM28_W:0], imm};
		return {{(64-isa_pkg::IMM28_W){imm[isa_pkg::IMM28_W-1]}}, imm};
	endfunction

	// Memory displacement, handled the same way
	function automatic logic [63:0] disp_imm(input logic has, input logic [63:0] cnst,
		input logic [19:0] imm);
		if (has)
			return {cnst[63-isa_pkg::IMM20_W:0], imm};
		return {{(64-isa_pkg::IMM20_W){imm[isa_pkg::IMM20_W-1]}}, imm};
	endfunction

	assign opc   = isa_pkg::opcode_e'(st_insn[isa_pkg::OPC_POS +: isa_pkg::OPC_W]);
	assign rd    = st_insn[isa_pkg::RD_POS +: isa_pkg::REG_W];
	assign rs1   = st_insn[isa_pkg::RS1_POS +: isa_pkg::REG_W];
	assign rs2   = st_insn[isa_pkg::RS2_POS +: isa_pkg::REG_W];
	assign rs3   = st_insn[isa_pkg::RS3_POS +: isa_pkg::REG_W];
	assign imm20 = st_insn[isa_pkg::IMM20_POS +: isa_pkg::IMM20_W];
	assign imm28 = st_insn[isa_pkg::IMM28_POS +: isa_pkg::IMM28_W];

	// ==================================================
	// Immediate selection
	// ==================================================

	always_comb begin
		imma_nx  = '0;
		immb_nx  = '0;
		immc_nx  = '0;
		immd_nx  = '0;
		has_a_nx = 1'b0;
		has_b_nx = 1'b0;
		has_c_nx = 1'b0;
		has_d_nx = 1'b0;
		case (opc)
			// Register operands turn into immediates only when a constant is given
			isa_pkg::OP_R3: begin
				has_a_nx = has_cnsta;
				has_b_nx = has_cnstb;
				has_c_nx = has_cnstc;
				if (has_cnsta)
					imma_nx = ext_reg(cnsta, rs1);
				if (has_cnstb)
					immb_nx = ext_reg(cnstb, rs2);
				if (has_cnstc)
					immc_nx = ext_reg(cnstc, rs3);
			end
			isa_pkg::OP_ADDI, isa_pkg::OP_ANDI, isa_pkg::OP_ORI: begin
				immb_nx  = quick_imm(has_cnstb, cnstb, imm28);
				has_b_nx = 1'b1;
			end
			// Load immediate adds to an explicit zero
			isa_pkg::OP_LOADI: begin
				has_a_nx = 1'b1;
				immb_nx  = quick_imm(has_cnstb, cnstb, imm28);
				has_b_nx = 1'b1;
			end
			// Memory and branch forms share the base and index handling
			isa_pkg::OP_LOAD, isa_pkg::OP_STORE, isa_pkg::OP_BCC: begin
				if (rs1 == isa_pkg::REG_ZERO) begin
					has_a_nx = 1'b1;
				end else if (rs1 == isa_pkg::REG_IP && st_ip_rel_en && opc != isa_pkg::OP_BCC) begin
					imma_nx  = st_ip;
					has_a_nx = 1'b1;
				end
				// A constant beats both special registers
				if (has_cnsta) begin
					imma_nx  = ext_reg(cnsta, rs1);
					has_a_nx = 1'b1;
				end
				if (rs2 == isa_pkg::REG_ZERO)
					has_b_nx = 1'b1;
				if (has_cnstb) begin
					immb_nx  = ext_reg(cnstb, rs2);
					has_b_nx = 1'b1;
				end
				// Branches carry no displacement here
				if (opc != isa_pkg::OP_BCC) begin
					immc_nx  = disp_imm(has_cnstc, cnstc, imm20);
					has_c_nx = 1'b1;
				end
				// Store data may itself be a constant
				if (opc == isa_pkg::OP_STORE && has_cnstd) begin
					immd_nx  = ext_reg(cnstd, rd);
					has_d_nx = 1'b1;
				end
			end
			isa_pkg::OP_FENCE: begin
				immb_nx  = {{(64-isa_pkg::FENCE_W){1'b0}},
					st_insn[isa_pkg::FENCE_POS +: isa_pkg::FENCE_W]};
				has_b_nx = 1'b1;
			end
			default: begin
				has_a_nx = 1'b0;
			end
		endcase
	end

	// ==================================================
	// Output registers
	// ==================================================

	// Flags only rise for a valid group
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			has_imma  <= 1'b0;
			has_immb  <= 1'b0;
			has_immc  <= 1'b0;
			has_immd  <= 1'b0;
		end else begin
			out_valid <= st_valid;
			has_imma  <= st_valid & has_a_nx;
			has_immb  <= st_valid & has_b_nx;
			has_immc  <= st_valid & has_c_nx;
			has_immd  <= st_valid & has_d_nx;
		end
	end

	always_ff @(posedge clk) begin
		imma     <= imma_nx;
		immb     <= immb_nx;
		immc     <= immc_nx;
		immd     <= immd_nx;
		pfx_used <= st_pfx_used;
	end

endmodule

//--- logic/const_decode_top.sv
// Constant decode top level: configuration block, postfix scan stage, immediate select stage
module const_decode_top #(
	parameter int NUM_PFX = 6
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  in_valid,
	input  logic [isa_pkg::INSN_W*(NUM_PFX+1)-1:0] in_group,
	input  logic [63:0]                           in_ip,
	input  logic                                  cfg_we,
	input  postfix_pkg::cfg_addr_e                cfg_addr,
	input  logic [7:0]                            cfg_wdata,
	output logic [7:0]                            cfg_rdata,
	output logic                                  out_valid,
	output logic [63:0]                           imma,
	output logic [63:0]                           immb,
	output logic [63:0]                           immc,
	output logic [63:0]                           immd,
	output logic                                  has_imma,
	output logic                                  has_immb,
	output logic                                  has_immc,
	output logic                                  has_immd,
	output logic [2:0]                            pfx_used
);

	// Configuration to the scan stage
	logic [2:0] max_pfx;
	logic       ip_rel_en;

	// Scan stage to select stage
	logic        st_valid;
	logic [47:0] st_insn;
	logic [63:0] st_ip;
	logic        st_ip_rel_en;
	logic [63:0] cnsta;
	logic [63:0] cnstb;
	logic [63:0] cnstc;
	logic [63:0] cnstd;
	logic        has_cnsta;
	logic        has_cnstb;
	logic        has_cnstc;
	logic        has_cnstd;
	logic [2:0]  st_pfx_used;

	decode_cfg #(.NUM_PFX(NUM_PFX)) decode_cfg_inst (
		.clk(clk), .reset(reset), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata), .max_pfx(max_pfx), .ip_rel_en(ip_rel_en)
	);

	postfix_scan #(.NUM_PFX(NUM_PFX)) postfix_scan_inst (
		.clk(clk), .reset(reset), .in_valid(in_valid), .in_group(in_group), .in_ip(in_ip),
		.max_pfx(max_pfx), .ip_rel_en(ip_rel_en),
		.st_valid(st_valid), .st_insn(st_insn), .st_ip(st_ip), .st_ip_rel_en(st_ip_rel_en),
		.cnsta(cnsta), .cnstb(cnstb), .cnstc(cnstc), .cnstd(cnstd),
		.has_cnsta(has_cnsta), .has_cnstb(has_cnstb), .has_cnstc(has_cnstc),
		.has_cnstd(has_cnstd), .st_pfx_used(st_pfx_used)
	);

	imm_select imm_select_inst (
		.clk(clk), .reset(reset),
		.st_valid(st_valid), .st_insn(st_insn), .st_ip(st_ip), .st_ip_rel_en(st_ip_rel_en),
		.cnsta(cnsta), .cnstb(cnstb), .cnstc(cnstc), .cnstd(cnstd),
		.has_cnsta(has_cnsta), .has_cnstb(has_cnstb), .has_cnstc(has_cnstc),
		.has_cnstd(has_cnstd), .st_pfx_used(st_pfx_used),
		.out_valid(out_valid), .imma(imma), .immb(immb), .immc(immc), .immd(immd),
		.has_imma(has_imma), .has_immb(has_immb), .has_immc(has_immc), .has_immd(has_immd),
		.pfx_used(pfx_used)
	);

endmodule

//--- dv/const_decode_ref.svh
// Reference model of the constant decoder: postfix run, constants, immediates, flags, count
`ifndef CONST_DECODE_REF_SVH
`define CONST_DECODE_REF_SVH

// Result layout from the top: pfx_used, has flags a to d, then imma, immb, immc and immd
function automatic logic [EXP_W-1:0] ref_decode(input logic [GRP_W-1:0] grp,
	input logic [63:0] ip, input int lim, input bit ip_rel);
	logic [63:0] cn [4];
	bit          hs [4];
	logic [63:0] imm [4];
	bit          has [4];
	logic [47:0] insn;
	logic [47:0] w;
	logic [35:0] pay;
	logic [6:0]  opc;
	logic [5:0]  rs1;
	logic [5:0]  rs2;
	int          used;
	int          sl;
	insn = grp[47:0];
	opc  = insn[6:0];
	rs1  = insn[18:13];
	rs2  = insn[24:19];
	used = 0;
	for (int s = 0; s < 4; s++) begin
		cn[s]  = '0;
		hs[s]  = 1'b0;
		imm[s] = '0;
		has[s] = 1'b0;
	end
	// The run is still going only while every earlier word was taken
	for (int n = 1; n <= NUM_PFX; n++) begin
		w = grp[n*48 +: 48];
		if (used == n - 1 && used < lim && w[7:0] == postfix_pkg::PFX_MARK) begin
			sl  = int'(w[9:8]);
			pay = w[47:12];
			// High half swaps in the top 28 bits, low half sign-extends the payload
			if (w[10])
				cn[sl] = {pay[27:0], cn[sl][35:0]};
			else
				cn[sl] = {{28{pay[35]}}, pay};
			hs[sl] = 1'b1;
			used++;
		end
	end
	case (opc)
		isa_pkg::OP_R3: begin
			for (int s = 0; s < 3; s++) begin
				has[s] = hs[s];
				if (hs[s])
					imm[s] = (cn[s] << 6) | 64'(insn[13 + 6*s +: 6]);
			end
		end
		isa_pkg::OP_ADDI, isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_LOADI: begin
			has[0] = (opc == isa_pkg::OP_LOADI);
			has[1] = 1'b1;
			imm[1] = hs[1] ? ((cn[1] << 28) | 64'(insn[47:20])) : {{36{insn[47]}}, insn[47:20]};
		end
		isa_pkg::OP_LOAD, isa_pkg::OP_STORE, isa_pkg::OP_BCC: begin
			// Base register: zero, then ip when allowed, and a constant beats both
			if (rs1 == isa_pkg::REG_ZERO) begin
				has[0] = 1'b1;
			end else if (rs1 == isa_pkg::REG_IP && ip_rel && opc != isa_pkg::OP_BCC) begin
				has[0] = 1'b1;
				imm[0] = ip;
			end
			if (hs[0]) begin
				has[0] = 1'b1;
				imm[0] = (cn[0] << 6) | 64'(rs1);
			end
			has[1] = (rs2 == isa_pkg::REG_ZERO) || hs[1];
			if (hs[1])
				imm[1] = (cn[1] << 6) | 64'(rs2);
			if (opc != isa_pkg::OP_BCC) begin
				has[2] = 1'b1;
				imm[2] = hs[2] ? ((cn[2] << 20) | 64'(insn[47:28])) : {{44{insn[47]}}, insn[47:28]};
			end
			if (opc == isa_pkg::OP_STORE && hs[3]) begin
				has[3] = 1'b1;
				imm[3] = (cn[3] << 6) | 64'(insn[12:7]);
			end
		end
		isa_pkg::OP_FENCE: begin
			has[1] = 1'b1;
			imm[1] = 64'(insn[23:8]);
		end
	endcase
	return {3'(used), has[0], has[1], has[2], has[3], imm[0], imm[1], imm[2], imm[3]};
endfunction

`endif

//--- dv/const_decode_tb.sv
// Constant decoder testbench: clock, reset, watchdog, stimulus, expected queue, compare process
module const_decode_tb;

	localparam int NUM_PFX  = 6;
	localparam int GRP_W    = isa_pkg::INSN_W * (NUM_PFX + 1);
	localparam int EXP_W    = 3 + 4 + 4 * 64;
	// Groups that the test sequence sends, each allowed 20 cycles
	localparam int N_GROUPS = 3 * 5 + 40 + 10 + 2 * 3 * 2 + 2 + 300;
	localparam int WATCHDOG = (N_GROUPS * 20 + 4) * 10;

	logic                   clk = 1'b0;
	logic                   reset;
	logic                   in_valid;
	logic [GRP_W-1:0]       in_group;
	logic [63:0]            in_ip;
	logic                   cfg_we;
	postfix_pkg::cfg_addr_e cfg_addr;
	logic [7:0]             cfg_wdata;
	logic [7:0]             cfg_rdata;
	logic                   out_valid;
	logic [63:0]            imma;
	logic [63:0]            immb;
	logic [63:0]            immc;
	logic [63:0]            immd;
	logic                   has_imma;
	logic                   has_immb;
	logic                   has_immc;
	logic                   has_immd;
	logic [2:0]             pfx_used;

	// Expected results in strobe order, and the cycle at which each is due
	logic [EXP_W-1:0] exp_q [$];
	int               due_q [$];
	int               cyc = 0;
	// Configuration as last written by the stimulus
	int               cfg_lim = NUM_PFX;
	bit               cfg_iprel = 1'b1;

	`include "const_decode_ref.svh"

	const_decode_top #(.NUM_PFX(NUM_PFX)) const_decode_top_inst (
		.clk(clk), .reset(reset), .in_valid(in_valid), .in_group(in_group), .in_ip(in_ip),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
		.out_valid(out_valid), .imma(imma), .immb(immb), .immc(immc), .immd(immd),
		.has_imma(has_imma), .has_immb(has_immb), .has_immc(has_immc), .has_immd(has_immd),
		.pfx_used(pfx_used)
	);

	always #5 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// ==================================================
	// Error handling and checks
	// ==================================================

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			$display("FAIL time %0t %s expected %h actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_result();
		logic [EXP_W-1:0] e;
		int               due;
		if (exp_q.size() == 0) begin
			$display("ERROR: out_valid at time %0t with no group waiting for a result", $time);
			abort_run();
		end else begin
			e   = exp_q.pop_front();
			due = due_q.pop_front();
			check_value("out_valid cycle", 64'(due), 64'(cyc));
			check_value("pfx_used", 64'(e[262:260]), 64'(pfx_used));
			check_value("has_imma", 64'(e[259]), 64'(has_imma));
			check_value("has_immb", 64'(e[258]), 64'(has_immb));
			check_value("has_immc", 64'(e[257]), 64'(has_immc));
			check_value("has_immd", 64'(e[256]), 64'(has_immd));
			check_value("imma", e[255:192], imma);
			check_value("immb", e[191:128], immb);
			check_value("immc", e[127:64], immc);
			check_value("immd", e[63:0], immd);
		end
	endtask

	// Outputs are sampled mid-cycle away from the edge that updates them
	always @(negedge clk) begin
		if (!reset && out_valid)
			compare_result();
	end

	initial begin
		#(WATCHDOG);
		$display("ERROR: watchdog timeout, the test sequence did not finish in time");
		abort_run();
	end

	// ==================================================
	// Stimulus helpers
	// ==================================================

	function automatic logic [47:0] rand_word();
		logic [63:0] r;
		r = {$urandom(), $urandom()};
		return r[47:0];
	endfunction

	// Opcodes 0 to 8 come in a fixed order and anything higher gives a raw random code
	function automatic logic [6:0] opc_of(input int i);
		case (i)
			0: return isa_pkg::OP_R3;
			1: return isa_pkg::OP_ADDI;
			2: return isa_pkg::OP_ANDI;
			3: return isa_pkg::OP_ORI;
			4: return isa_pkg::OP_LOADI;
			5: return isa_pkg::OP_FENCE;
			6: return isa_pkg::OP_LOAD;
			7: return isa_pkg::OP_STORE;
			8: return isa_pkg::OP_BCC;
			default: return 7'($urandom());
		endcase
	endfunction

	// Special registers show up often so that the base and index cases get hit
	function automatic logic [5:0] rand_reg();
		case ($urandom_range(0, 3))
			0: return isa_pkg::REG_ZERO;
			1: return isa_pkg::REG_IP;
			default: return 6'($urandom());
		endcase
	endfunction

	function automatic logic [47:0] make_insn(input logic [6:0] opc, input logic [5:0] rs1,
		input logic [5:0] rs2);
		logic [47:0] w;
		w        = rand_word();
		w[6:0]   = opc;
		w[18:13] = rs1;
		w[24:19] = rs2;
		return w;
	endfunction

	function automatic logic [47:0] pfx_word(input postfix_pkg::slot_e slot, input bit half,
		input logic [35:0] pay);
		return {pay, 1'b0, half, slot, postfix_pkg::PFX_MARK};
	endfunction

	// Random postfix words in positions 1 to npfx and an unmarked word right after them.
	// Marked words behind the unmarked one have to be ignored
	function automatic logic [GRP_W-1:0] build_group(input logic [47:0] insn, input int npfx);
		logic [GRP_W-1:0] g;
		logic [47:0]      w;
		g[47:0] = insn;
		for (int n = 1; n <= NUM_PFX; n++) begin
			w      = rand_word();
			w[7:0] = (n == npfx + 1) ? 8'h3c : postfix_pkg::PFX_MARK;
			g[n*48 +: 48] = w;
		end
		return g;
	endfunction

	// Strobe for one cycle; a following call in the same step keeps the strobe high
	task automatic send_group(input logic [GRP_W-1:0] grp, input logic [63:0] ip);
		in_valid = 1'b1;
		in_group = grp;
		in_ip    = ip;
		exp_q.push_back(ref_decode(grp, ip, cfg_lim, cfg_iprel));
		due_q.push_back(cyc + 2);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic write_cfg(input postfix_pkg::cfg_addr_e addr, input logic [7:0] data);
		cfg_we    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		if (addr == postfix_pkg::CFG_MAX_PFX)
			cfg_lim = (int'(data) > NUM_PFX) ? NUM_PFX : int'(data);
		else
			cfg_iprel = data[0];
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	task automatic read_cfg(input postfix_pkg::cfg_addr_e addr, input logic [7:0] exp);
		cfg_addr = addr;
		#1;
		check_value("cfg_rdata", 64'(exp), 64'(cfg_rdata));
		@(negedge clk);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		logic [GRP_W-1:0] g;
		void'($urandom(45950));
		reset     = 1'b1;
		in_valid  = 1'b0;
		in_group  = '0;
		in_ip     = '0;
		cfg_we    = 1'b0;
		cfg_addr  = postfix_pkg::CFG_MAX_PFX;
		cfg_wdata = 8'd0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// Idle outputs and configuration defaults
		check_value("out_valid", 64'd0, 64'(out_valid));
		check_value("has_imma", 64'd0, 64'(has_imma));
		check_value("has_immb", 64'd0, 64'(has_immb));
		check_value("has_immc", 64'd0, 64'(has_immc));
		check_value("has_immd", 64'd0, 64'(has_immd));
		read_cfg(postfix_pkg::CFG_MAX_PFX, 8'd6);
		read_cfg(postfix_pkg::CFG_IP_REL, 8'd1);

		// Quick immediates and fences back to back, no postfix words
		for (int r = 0; r < 3; r++) begin
			for (int i = 1; i <= 5; i++)
				send_group(build_group(make_insn(opc_of(i), rand_reg(), rand_reg()), 0),
					{$urandom(), $urandom()});
			@(negedge clk);
		end

		// Random postfix runs over the opcodes that take constants
		for (int i = 0; i < 40; i++)
			send_group(build_group(make_insn(opc_of($urandom_range(0, 8)), rand_reg(),
				rand_reg()), $urandom_range(0, NUM_PFX)), {$urandom(), $urandom()});

		// Postfix limit of two, then a write above the group size
		write_cfg(postfix_pkg::CFG_MAX_PFX, 8'd2);
		read_cfg(postfix_pkg::CFG_MAX_PFX, 8'd2);
		for (int i = 0; i < 10; i++)
			send_group(build_group(make_insn(opc_of(i % 2 == 0 ? 0 : 7), rand_reg(), rand_reg()),
				$urandom_range(3, NUM_PFX)), {$urandom(), $urandom()});
		write_cfg(postfix_pkg::CFG_MAX_PFX, 8'd9);
		read_cfg(postfix_pkg::CFG_MAX_PFX, 8'd6);

		// Special base registers with ip-relative on and then off
		for (int on = 1; on >= 0; on--) begin
			write_cfg(postfix_pkg::CFG_IP_REL, 8'(on));
			for (int i = 6; i <= 8; i++) begin
				send_group(build_group(make_insn(opc_of(i), isa_pkg::REG_ZERO,
					isa_pkg::REG_ZERO), 0), {$urandom(), $urandom()});
				send_group(build_group(make_insn(opc_of(i), isa_pkg::REG_IP, 6'($urandom())), 0),
					{$urandom(), $urandom()});
			end
		end
		write_cfg(postfix_pkg::CFG_IP_REL, 8'd1);

		// Store data from a d-slot constant, first low half alone, then both halves
		g = build_group(make_insn(isa_pkg::OP_STORE, isa_pkg::REG_IP, isa_pkg::REG_ZERO), 1);
		g[48 +: 48] = pfx_word(postfix_pkg::SLOT_D, 1'b0, 36'($urandom()) | 36'h8_0000_0000);
		send_group(g, {$urandom(), $urandom()});
		g = build_group(make_insn(isa_pkg::OP_STORE, 6'($urandom()), 6'($urandom())), 2);
		g[48 +: 48] = pfx_word(postfix_pkg::SLOT_D, 1'b0, 36'($urandom()));
		g[96 +: 48] = pfx_word(postfix_pkg::SLOT_D, 1'b1, 36'($urandom()));
		send_group(g, {$urandom(), $urandom()});

		// Random traffic with configuration writes in between
		for (int i = 0; i < 300; i++) begin
			if ($urandom_range(0, 9) == 0)
				write_cfg(postfix_pkg::cfg_addr_e'($urandom_range(0, 1)),
					8'($urandom_range(0, 9)));
			send_group(build_group(make_insn(opc_of($urandom_range(0, 9)), rand_reg(),
				rand_reg()), $urandom_range(0, NUM_PFX)), {$urandom(), $urandom()});
			if ($urandom_range(0, 3) == 0)
				@(negedge clk);
		end

		// The pipeline is two deep, so four cycles drain it
		repeat (4) @(negedge clk);
		if (exp_q.size() == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("ERROR: %0d expected results never came out of the DUT", exp_q.size());
			abort_run();
		end
	end

endmodule

//--- const_decode.f
+incdir+dv
logic/isa_pkg.sv
logic/postfix_pkg.sv
logic/decode_cfg.sv
logic/postfix_scan.sv
logic/imm_select.sv
logic/const_decode_top.sv
dv/const_decode_tb.sv

//--- Makefile
# Verilator build for the constant decoder testbench
TOP := const_decode_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f const_decode.f -Mdir obj_dir

# The simulation passes only when the log holds the pass line
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
